/* Bender.yml */
package:
  name: fetch_subsystem

sources:
  - common/fetch_pkg.sv
  - common/fetch_stream_if.sv
  - rtl/pc_select.sv
  - prefetch/prefetch_buffer.sv
  - rtl/compressed_expander.sv
  - rtl/fetch_ctrl.sv
  - rtl/fetch_top.sv
  - target: simulation
    files:
      - verification/tb_wb_mem.sv
      - verification/tb_fetch_top.sv

/* common/fetch_pkg.sv */
/* shared types and constants of the fetch subsystem; XLEN is fixed at 32 and
   the compressed helpers cover only the RV32C subset that the expander handles */
package fetch_pkg;

  localparam int XLEN = 32;

  //////////////////////////////////////////////////
  // selector encodings
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_MRET      = 3'd4,
    PC_DRET      = 3'd5,
    PC_FENCEI    = 3'd6
  } pc_mux_e;

  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,  // synchronous trap
    EXC_PC_IRQ       = 2'd1,  // vectored interrupt
    EXC_PC_DBD       = 2'd2   // debug halt
  } exc_pc_mux_e;

  typedef enum logic {
    FETCH_IDLE = 1'b0,
    FETCH_WAIT = 1'b1
  } fetch_state_e;

  // instr[1:0], value 3 is a full 32-bit word
  typedef enum logic [1:0] {
    C_Q0 = 2'd0,
    C_Q1 = 2'd1,
    C_Q2 = 2'd2
  } c_opcode_e;

  //////////////////////////////////////////////////
  // helpers for the compressed expander
  //////////////////////////////////////////////////

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;

  // 3-bit register field maps onto x8..x15
  function automatic logic [4:0] c_reg(input logic [2:0] r);
    return {2'b01, r};
  endfunction

endpackage

/* common/fetch_stream_if.sv */
/* word stream from the prefetch queue to fetch control; valid never waits on
   ready and the payload holds while valid is high */
`timescale 1ns/1ps

interface fetch_stream_if;
  import fetch_pkg::*;

  logic            valid;  // head of queue present
  logic            ready;  // sink takes the word this edge
  logic [XLEN-1:0] rdata;  // raw fetched word
  logic [XLEN-1:0] addr;   // word address of rdata
  logic            err;    // bus error on this fetch

  modport src (
    output valid, rdata, addr, err,
    input  ready
  );

  modport snk (
    input  valid, rdata, addr, err,
    output ready
  );

endinterface

/* flist.f */
common/fetch_pkg.sv
common/fetch_stream_if.sv
rtl/pc_select.sv
prefetch/prefetch_buffer.sv
rtl/compressed_expander.sv
rtl/fetch_ctrl.sv
rtl/fetch_top.sv
verification/tb_wb_mem.sv
verification/tb_fetch_top.sv

/* prefetch/prefetch_buffer.sv */
/* single-beat Wishbone classic reads, one cycle outstanding at most; all
   addresses are word aligned and FIFO_DEPTH must be a power of two, 2 or more */
`timescale 1ns/1ps

module prefetch_buffer #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_i,
  input  logic                        branch_i,
  input  logic [fetch_pkg::XLEN-1:0]  branch_addr_i,
  fetch_stream_if.src                 out,
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic [fetch_pkg::XLEN-1:0]  wb_adr_o,
  input  logic                        wb_ack_i,
  input  logic                        wb_err_i,
  input  logic [fetch_pkg::XLEN-1:0]  wb_dat_i,
  output logic                        busy_o
);
  import fetch_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [XLEN-1:0]  fetch_addr_q;  // next sequential word
  logic [XLEN-1:0]  adr_q;         // address of the open cycle
  logic             cyc_q;         // bus cycle open
  logic             discard_q;     // open cycle overtaken by a branch

  logic [XLEN-1:0]  data_mem [FIFO_DEPTH];
  logic [XLEN-1:0]  addr_mem [FIFO_DEPTH];
  logic             err_mem  [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   count_q;

  logic [XLEN-1:0]  issue_addr;
  logic             resp, push, pop, room, start;

  //////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////

  assign resp = cyc_q & (wb_ack_i | wb_err_i);
  assign push = resp & ~discard_q & ~branch_i;  // stale or flushed responses dropped
  assign pop  = out.valid & out.ready;

  // queued words plus the one in flight must stay below depth
  assign room = (int'(count_q) + int'(cyc_q)) < FIFO_DEPTH;

  // a branch goes straight to its target, otherwise continue sequentially
  assign issue_addr = branch_i ? {branch_addr_i[XLEN-1:2], 2'b00}
                               : {fetch_addr_q[XLEN-1:2], 2'b00};

  // cyc_q low for the cycle after ack keeps the mandatory idle gap
  assign start = ~cyc_q & req_i & (branch_i | room);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q        <= 1'b0;
      discard_q    <= 1'b0;
      adr_q        <= '0;
      fetch_addr_q <= '0;
    end else begin
      if (resp) begin
        cyc_q     <= 1'b0;
        discard_q <= 1'b0;
      end else if (branch_i && cyc_q) begin
        discard_q <= 1'b1;  // let the cycle finish, throw the data away
      end
      if (start) begin
        cyc_q        <= 1'b1;
        adr_q        <= issue_addr;
        fetch_addr_q <= issue_addr + XLEN'(4);
      end else if (branch_i) begin
        fetch_addr_q <= issue_addr;  // issued once the old cycle closes
      end
    end
  end

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = adr_q;

  //////////////////////////////////////////////////
  // instruction queue
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (branch_i) begin
      wr_ptr_q <= '0;  // flush
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr_q] <= wb_dat_i;
      addr_mem[wr_ptr_q] <= adr_q;
      err_mem[wr_ptr_q]  <= wb_err_i;
    end
  end

  assign out.valid = (count_q != '0);
  assign out.rdata = data_mem[rd_ptr_q];
  assign out.addr  = addr_mem[rd_ptr_q];
  assign out.err   = err_mem[rd_ptr_q];

  assign busy_o = cyc_q | (count_q != '0);

endmodule

/* rtl/compressed_expander.sv */
/* combinational; only c.addi c.li c.lw c.sw c.j c.mv c.add are expanded, any
   other 16-bit encoding is flagged illegal and passed through as is */
`timescale 1ns/1ps

module compressed_expander (
  input  logic [fetch_pkg::XLEN-1:0] instr_i,
  output logic [fetch_pkg::XLEN-1:0] instr_o,
  output logic                       is_compressed_o,
  output logic                       illegal_o
);
  import fetch_pkg::*;

  c_opcode_e   quad;
  logic [2:0]  funct3;
  logic [4:0]  rd;        // full rd/rs1 field
  logic [4:0]  rs2;       // full rs2 field
  logic [4:0]  rd_p;      // rd' / rs2' in x8..x15
  logic [4:0]  rs1_p;     // rs1' in x8..x15
  logic [11:0] imm6_sx;   // sign extended ci immediate
  logic [11:0] lw_off;    // zero extended word offset

  assign quad    = c_opcode_e'(instr_i[1:0]);
  assign funct3  = instr_i[15:13];
  assign rd      = instr_i[11:7];
  assign rs2     = instr_i[6:2];
  assign rd_p    = c_reg(instr_i[4:2]);
  assign rs1_p   = c_reg(instr_i[9:7]);
  assign imm6_sx = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};
  assign lw_off  = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00};

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i;  // full words and illegal ones pass through
    illegal_o = 1'b0;

    if (is_compressed_o) begin
      illegal_o = 1'b1;  // cleared by each supported encoding
      unique case (quad)
        C_Q0: begin
          if (funct3 == 3'b010) begin          // c.lw
            instr_o   = {lw_off, rs1_p, 3'b010, rd_p, OPC_LOAD};
            illegal_o = 1'b0;
          end else if (funct3 == 3'b110) begin // c.sw
            instr_o   = {lw_off[11:5], rd_p, rs1_p, 3'b010, lw_off[4:0], OPC_STORE};
            illegal_o = 1'b0;
          end
        end

        C_Q1: begin
          if (funct3 == 3'b000) begin          // c.addi
            instr_o   = {imm6_sx, rd, 3'b000, rd, OPC_OPIMM};
            illegal_o = 1'b0;
          end else if (funct3 == 3'b010) begin // c.li
            instr_o   = {imm6_sx, 5'd0, 3'b000, rd, OPC_OPIMM};
            illegal_o = 1'b0;
          end else if (funct3 == 3'b101) begin // c.j, jal x0
            instr_o   = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                         instr_i[7], instr_i[2], instr_i[11], instr_i[5:3],
                         instr_i[12], {8{instr_i[12]}}, 5'd0, OPC_JAL};
            illegal_o = 1'b0;
          end
        end

        C_Q2: begin
          // c.mv / c.add, rs2 of zero belongs to c.jr/c.jalr
          if (funct3 == 3'b100 && rs2 != 5'd0) begin
            if (instr_i[12]) begin
              instr_o = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};     // c.add
            end else begin
              instr_o = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP};   // c.mv
            end
            illegal_o = 1'b0;
          end
        end

        default: ;
      endcase
    end
  end

endmodule

/* rtl/fetch_ctrl.sv */
/* the IF/ID register holds while decode stalls; a pc set always wins over
   acceptance in the same cycle */
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,
  input  logic                       pc_set_i,
  input  logic                       clear_instr_valid_i,
  input  logic                       halt_if_i,
  input  logic                       id_ready_i,
  fetch_stream_if.snk                in,
  output logic                       branch_o,
  input  logic [fetch_pkg::XLEN-1:0] exp_instr_i,
  input  logic                       exp_compressed_i,
  input  logic                       exp_illegal_i,
  output logic                       instr_valid_id_o,
  output logic [fetch_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic                       is_compressed_id_o,
  output logic                       illegal_c_insn_id_o,
  output logic [fetch_pkg::XLEN-1:0] pc_id_o,
  output logic                       fetch_err_id_o,
  output logic                       perf_imiss_o
);
  import fetch_pkg::*;

  fetch_state_e state_q, state_n;
  logic         accept;  // word moves into IF/ID this edge

  //////////////////////////////////////////////////
  // fetch FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= FETCH_IDLE;
    else        state_q <= state_n;
  end

  always_comb begin
    state_n  = state_q;
    branch_o = 1'b0;

    unique case (state_q)
      FETCH_IDLE: begin
        if (req_i) begin
          branch_o = 1'b1;  // first fetch from the selected address
          state_n  = FETCH_WAIT;
        end
      end
      FETCH_WAIT: ;         // stay, words flow through ready
    endcase

    // redirect from any state, offered word is dropped by the flush
    if (pc_set_i) begin
      branch_o = 1'b1;
      state_n  = FETCH_WAIT;
    end
  end

  // ready is independent of valid
  assign in.ready = (state_q == FETCH_WAIT) & ~pc_set_i & req_i & id_ready_i & ~halt_if_i;
  assign accept   = in.valid & in.ready;

  assign perf_imiss_o = ~in.valid | branch_o;

  //////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
      fetch_err_id_o   <= 1'b0;
    end else if (accept) begin
      instr_valid_id_o <= 1'b1;
      fetch_err_id_o   <= in.err;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o <= 1'b0;  // decode consumed it, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      instr_rdata_id_o    <= exp_instr_i;
      is_compressed_id_o  <= exp_compressed_i;
      illegal_c_insn_id_o <= exp_illegal_i;
      pc_id_o             <= in.addr;
    end
  end

endmodule

/* rtl/fetch_top.sv */
/* instruction fetch subsystem top; memory must answer every cycle with ack
   or err, latency to instr_valid_id_o follows the ack delay */
`timescale 1ns/1ps

module fetch_top #(
  parameter int FIFO_DEPTH       = 2,
  parameter bit IGNORE_CAUSE_MSB = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // control from the core
  input  logic                       req_i,
  input  logic                       pc_set_i,
  input  fetch_pkg::pc_mux_e         pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e     exc_pc_mux_i,
  input  logic [30:0]                boot_addr_i,
  input  logic [23:0]                trap_base_addr_i,
  input  logic [5:0]                 irq_cause_i,
  input  logic [29:0]                dm_halt_addr_i,
  input  logic [fetch_pkg::XLEN-1:0] mepc_i,
  input  logic [fetch_pkg::XLEN-1:0] depc_i,
  input  logic [fetch_pkg::XLEN-1:0] jump_target_id_i,
  input  logic [fetch_pkg::XLEN-1:0] jump_target_ex_i,
  input  logic                       clear_instr_valid_i,
  input  logic                       halt_if_i,
  input  logic                       id_ready_i,
  // Wishbone classic master
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic [fetch_pkg::XLEN-1:0] wb_adr_o,
  input  logic                       wb_ack_i,
  input  logic                       wb_err_i,
  input  logic [fetch_pkg::XLEN-1:0] wb_dat_i,
  // IF/ID and status
  output logic                       instr_valid_id_o,
  output logic [fetch_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic                       is_compressed_id_o,
  output logic                       illegal_c_insn_id_o,
  output logic [fetch_pkg::XLEN-1:0] pc_id_o,
  output logic                       fetch_err_id_o,
  output logic                       perf_imiss_o,
  output logic [fetch_pkg::XLEN-1:0] pc_if_o,
  output logic                       if_busy_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] fetch_addr_n;
  logic            branch;
  logic [XLEN-1:0] exp_instr;
  logic            exp_compressed, exp_illegal;

  fetch_stream_if fetch_stream ();

  assign pc_if_o = fetch_stream.addr;  // address of the offered word

  pc_select #(
    .IGNORE_CAUSE_MSB (IGNORE_CAUSE_MSB)
  ) i_pc_select (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .trap_base_addr_i (trap_base_addr_i),
    .irq_cause_i      (irq_cause_i),
    .dm_halt_addr_i   (dm_halt_addr_i),
    .mepc_i           (mepc_i),
    .depc_i           (depc_i),
    .jump_target_id_i (jump_target_id_i),
    .jump_target_ex_i (jump_target_ex_i),
    .pc_id_i          (pc_id_o),
    .fetch_addr_n_o   (fetch_addr_n)
  );

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_prefetch_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch),
    .branch_addr_i ({fetch_addr_n[XLEN-1:1], 1'b0}),
    .out           (fetch_stream.src),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_adr_o      (wb_adr_o),
    .wb_ack_i      (wb_ack_i),
    .wb_err_i      (wb_err_i),
    .wb_dat_i      (wb_dat_i),
    .busy_o        (if_busy_o)
  );

  // expands the head word before it reaches the IF/ID register
  compressed_expander i_compressed_expander (
    .instr_i         (fetch_stream.rdata),
    .instr_o         (exp_instr),
    .is_compressed_o (exp_compressed),
    .illegal_o       (exp_illegal)
  );

  fetch_ctrl i_fetch_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .in                  (fetch_stream.snk),
    .branch_o            (branch),
    .exp_instr_i         (exp_instr),
    .exp_compressed_i    (exp_compressed),
    .exp_illegal_i       (exp_illegal),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .is_compressed_id_o  (is_compressed_id_o),
    .illegal_c_insn_id_o (illegal_c_insn_id_o),
    .pc_id_o             (pc_id_o),
    .fetch_err_id_o      (fetch_err_id_o),
    .perf_imiss_o        (perf_imiss_o)
  );

endmodule

/* rtl/pc_select.sv */
/* purely combinational; trap vectors assume a 256-byte aligned trap base and
   a cause below 64 */
`timescale 1ns/1ps

module pc_select #(
  parameter bit IGNORE_CAUSE_MSB = 1'b0
) (
  input  fetch_pkg::pc_mux_e           pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e       exc_pc_mux_i,
  input  logic [30:0]                  boot_addr_i,
  input  logic [23:0]                  trap_base_addr_i,
  input  logic [5:0]                   irq_cause_i,
  input  logic [29:0]                  dm_halt_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]   mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]   depc_i,
  input  logic [fetch_pkg::XLEN-1:0]   jump_target_id_i,
  input  logic [fetch_pkg::XLEN-1:0]   jump_target_ex_i,
  input  logic [fetch_pkg::XLEN-1:0]   pc_id_i,
  output logic [fetch_pkg::XLEN-1:0]   fetch_addr_n_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] exc_pc;
  logic [5:0]      cause;  // cause after optional msb folding

  // fold upper 32 irqs onto the lower 32 when asked
  assign cause = IGNORE_CAUSE_MSB ? {1'b0, irq_cause_i[4:0]} : irq_cause_i;

  // exception target
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_IRQ: exc_pc = {trap_base_addr_i, cause, 2'b00};  // base + 4*cause
      EXC_PC_DBD: exc_pc = {dm_halt_addr_i, 2'b00};
      default:    exc_pc = {trap_base_addr_i, 8'h00};         // all sync traps share base
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      PC_JUMP:      fetch_addr_n_o = jump_target_id_i;
      PC_BRANCH:    fetch_addr_n_o = jump_target_ex_i;
      PC_EXCEPTION: fetch_addr_n_o = exc_pc;
      PC_MRET:      fetch_addr_n_o = mepc_i;
      PC_DRET:      fetch_addr_n_o = depc_i;
      PC_FENCEI:    fetch_addr_n_o = pc_id_i + XLEN'(4);  // refetch everything past the fence
      default:      fetch_addr_n_o = {boot_addr_i, 1'b0};
    endcase
  end

endmodule

/* verification/tb_fetch_top.sv */
/* directed tests of the fetch subsystem; runs stop at the first error and
   expected words come from the memory image and the RV32C rules */
`timescale 1ns/1ps

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int          TIMEOUT = 200;          // cycles per wait
  localparam logic [31:0] FILL_K  = 32'h9e37_79b1; // odd fill constant

  logic clk, rst_n, req, pc_set, clr_valid, halt_if, id_ready;
  pc_mux_e     pc_mux;
  exc_pc_mux_e exc_mux;
  logic [30:0] boot_addr;
  logic [23:0] trap_base;
  logic [5:0]  irq_cause;
  logic [29:0] dm_halt;
  logic [31:0] mepc, depc, jmp_id, jmp_ex;
  logic        cyc, stb, ack, err, err_en;
  logic [31:0] adr, dat, err_adr;
  logic        valid_id, comp_id, ill_id, ferr_id, imiss, busy;
  logic [31:0] rdata_id, pc_id, pc_if;
  logic [31:0] last_pc;  // pc of the last accepted word
  int          seed_ret;

  fetch_top #(.FIFO_DEPTH(2), .IGNORE_CAUSE_MSB(1'b0)) i_dut (
    .clk(clk), .rst_n(rst_n), .req_i(req), .pc_set_i(pc_set), .pc_mux_i(pc_mux),
    .exc_pc_mux_i(exc_mux), .boot_addr_i(boot_addr), .trap_base_addr_i(trap_base),
    .irq_cause_i(irq_cause), .dm_halt_addr_i(dm_halt), .mepc_i(mepc), .depc_i(depc),
    .jump_target_id_i(jmp_id), .jump_target_ex_i(jmp_ex),
    .clear_instr_valid_i(clr_valid), .halt_if_i(halt_if), .id_ready_i(id_ready),
    .wb_cyc_o(cyc), .wb_stb_o(stb), .wb_adr_o(adr), .wb_ack_i(ack), .wb_err_i(err),
    .wb_dat_i(dat), .instr_valid_id_o(valid_id), .instr_rdata_id_o(rdata_id),
    .is_compressed_id_o(comp_id), .illegal_c_insn_id_o(ill_id), .pc_id_o(pc_id),
    .fetch_err_id_o(ferr_id), .perf_imiss_o(imiss), .pc_if_o(pc_if), .if_busy_o(busy)
  );

  tb_wb_mem i_mem (
    .clk(clk), .rst_n(rst_n), .cyc_i(cyc), .stb_i(stb), .adr_i(adr),
    .err_en_i(err_en), .err_adr_i(err_adr), .ack_o(ack), .err_o(err), .dat_o(dat)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // RV32C subset, {illegal, compressed, word}
  function automatic logic [33:0] expand(input logic [31:0] w);
    logic [20:0] joff;
    logic [6:0]  woff;  // c.lw / c.sw byte offset
    logic [4:0]  rd, rs2, rp1, rp2;
    rd   = w[11:7];
    rs2  = w[6:2];
    rp1  = {2'b01, w[9:7]};
    rp2  = {2'b01, w[4:2]};
    woff = {w[5], w[12:10], w[6], 2'b00};
    joff = {{10{w[12]}}, w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
    if (w[1:0] == 2'b11) return {2'b00, w};
    case ({w[1:0], w[15:13]})
      5'b00_010: return {2'b01, 5'b0, woff, rp1, 3'b010, rp2, 7'b0000011};  // c.lw
      5'b00_110: return {2'b01, 5'b0, woff[6:5], rp2, rp1, 3'b010, woff[4:0], 7'b0100011};
      5'b01_000: return {2'b01, {7{w[12]}}, w[6:2], rd, 3'b000, rd, 7'b0010011};
      5'b01_010: return {2'b01, {7{w[12]}}, w[6:2], 5'd0, 3'b000, rd, 7'b0010011};
      5'b01_101: return {2'b01, joff[20], joff[10:1], joff[11], joff[19:12], 5'd0,
                         7'b1101111};  // c.j as jal x0
      5'b10_100: begin
        if (rs2 == 5'd0) return {2'b11, w};
        if (w[12]) return {2'b01, 7'b0, rs2, rd, 3'b000, rd, 7'b0110011};  // c.add
        return {2'b01, 7'b0, rs2, 5'd0, 3'b000, rd, 7'b0110011};            // c.mv
      end
      default: return {2'b11, w};
    endcase
  endfunction

  // redirect with a one-cycle pc set pulse, then one quiet cycle
  task automatic set_pc(input pc_mux_e m, input exc_pc_mux_e e);
    @(negedge clk);
    pc_mux  = m;
    exc_mux = e;
    pc_set  = 1'b1;
    @(negedge clk);
    check("perf_imiss_o", 32'(imiss), 32'd1);  // branch pending, queue flushed
    pc_set  = 1'b0;
    @(negedge clk);
  endtask

  // take exactly one word; clear makes each new acceptance visible
  // head status is the one seen on the falling edge before acceptance
  task automatic fetch_one(output logic [31:0] head_pc, output logic head_miss,
                           output logic head_busy);
    bit got;
    got = 1'b0;
    id_ready  = 1'b1;
    clr_valid = 1'b1;
    halt_if   = 1'b0;
    for (int i = 0; i < TIMEOUT && !got; i++) begin
      head_pc   = pc_if;  // still the offered word if the next edge accepts
      head_miss = imiss;
      head_busy = busy;
      @(negedge clk);
      got = valid_id;
    end
    id_ready  = 1'b0;
    clr_valid = 1'b0;
    if (!got) begin
      $display("timeout: no instruction reached the IF/ID register");
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic fetch_check(input logic [31:0] exp_pc, input logic exp_err);
    logic [33:0] e;
    logic [31:0] head_pc;
    logic        head_miss, head_busy;
    fetch_one(head_pc, head_miss, head_busy);
    e = expand(i_mem.mem[exp_pc[13:2]]);
    check("pc_if_o", head_pc, exp_pc);
    check("perf_imiss_o", 32'(head_miss), 32'd0);  // word offered, no branch
    check("if_busy_o", 32'(head_busy), 32'd1);      // queue holds the word
    check("pc_id_o", pc_id, exp_pc);
    check("instr_rdata_id_o", rdata_id, e[31:0]);
    check("is_compressed_id_o", 32'(comp_id), 32'(e[32]));
    check("illegal_c_insn_id_o", 32'(ill_id), 32'(e[33]));
    check("fetch_err_id_o", 32'(ferr_id), 32'(exp_err));
    last_pc = exp_pc;
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reset_and_boot();
    check("wb_cyc_o", 32'(cyc), 32'd0);
    check("wb_stb_o", 32'(stb), 32'd0);
    check("instr_valid_id_o", 32'(valid_id), 32'd0);
    check("fetch_err_id_o", 32'(ferr_id), 32'd0);
    check("if_busy_o", 32'(busy), 32'd0);
    check("perf_imiss_o", 32'(imiss), 32'd1);  // nothing offered yet
    @(negedge clk);
    req = 1'b1;
    set_pc(PC_BOOT, EXC_PC_EXCEPTION);
    for (int n = 0; n < 16; n++) fetch_check({boot_addr, 1'b0} + 32'(4 * n), 1'b0);
  endtask

  task automatic target_select();
    set_pc(PC_JUMP, EXC_PC_EXCEPTION);      fetch_check(jmp_id, 1'b0);
    set_pc(PC_BRANCH, EXC_PC_EXCEPTION);    fetch_check(jmp_ex, 1'b0);
    set_pc(PC_MRET, EXC_PC_EXCEPTION);      fetch_check(mepc, 1'b0);
    set_pc(PC_DRET, EXC_PC_EXCEPTION);      fetch_check(depc, 1'b0);
    set_pc(PC_FENCEI, EXC_PC_EXCEPTION);    fetch_check(last_pc + 32'd4, 1'b0);
    set_pc(PC_EXCEPTION, EXC_PC_EXCEPTION); fetch_check({trap_base, 8'h00}, 1'b0);
    set_pc(PC_EXCEPTION, EXC_PC_IRQ);
    fetch_check({trap_base, 8'h00} + 32'(4 * irq_cause), 1'b0);
    set_pc(PC_EXCEPTION, EXC_PC_DBD);       fetch_check({dm_halt, 2'b00}, 1'b0);
  endtask

  task automatic flush_open_cycle();
    bit open;
    open   = 1'b0;
    jmp_id = 32'h0000_0a00;
    set_pc(PC_JUMP, EXC_PC_EXCEPTION);
    for (int i = 0; i < TIMEOUT && !open; i++) begin
      @(negedge clk);
      open = cyc & ~ack & ~err;
    end
    if (!open) begin
      $display("timeout: no bus cycle opened before the flush");
      $display("ERRORS FOUND");
      $fatal(1);
    end
    check("wb_stb_o", 32'(stb), 32'd1);  // strobe travels with cyc
    check("if_busy_o", 32'(busy), 32'd1);
    jmp_id = 32'h0000_0c40;  // new target, old stream must vanish
    pc_set = 1'b1;
    @(negedge clk);
    pc_set = 1'b0;
    @(negedge clk);
    for (int n = 0; n < 4; n++) fetch_check(32'h0000_0c40 + 32'(4 * n), 1'b0);
  endtask

  task automatic back_pressure();
    logic [31:0] held;
    int          len;
    jmp_id = 32'h0000_0100;
    set_pc(PC_JUMP, EXC_PC_EXCEPTION);
    for (int n = 0; n < 12; n++) begin
      fetch_check(32'h0000_0100 + 32'(4 * n), 1'b0);
      held = rdata_id;
      len  = $urandom % 6;
      halt_if  = $urandom % 2;  // halt with ready high, or ready low
      id_ready = halt_if;
      repeat (len) begin
        @(negedge clk);
        check("instr_rdata_id_o", rdata_id, held);
      end
      halt_if  = 1'b0;
      id_ready = 1'b0;
    end
  endtask

  task automatic compressed_words();
    logic [15:0] c [8];
    c = '{16'h12f5, 16'h451d, 16'h4044, 16'hc588, 16'hb0f1, 16'h831e, 16'h931e, 16'h0000};
    for (int i = 0; i < 8; i++) i_mem.mem[12'hc00 + i] = {16'habcd, c[i]};
    jmp_id = 32'h0000_3000;
    set_pc(PC_JUMP, EXC_PC_EXCEPTION);
    for (int i = 0; i < 8; i++) fetch_check(32'h0000_3000 + 32'(4 * i), 1'b0);
  endtask

  task automatic bus_error_clear();
    err_adr = 32'h0000_3800;
    err_en  = 1'b1;
    jmp_id  = 32'h0000_37f8;
    set_pc(PC_JUMP, EXC_PC_EXCEPTION);
    fetch_check(32'h0000_37f8, 1'b0);
    fetch_check(32'h0000_37fc, 1'b0);
    fetch_check(32'h0000_3800, 1'b1);
    fetch_check(32'h0000_3804, 1'b0);
    err_en = 1'b0;
    check("instr_valid_id_o", 32'(valid_id), 32'd1);
    clr_valid = 1'b1;  // ready is low, so nothing is accepted
    @(negedge clk);
    clr_valid = 1'b0;
    check("instr_valid_id_o", 32'(valid_id), 32'd0);
  endtask

  //////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////

  initial begin
    seed_ret  = $urandom(32'h3ad9_afbf);
    rst_n     = 1'b0;
    req       = 1'b0;
    pc_set    = 1'b0;
    clr_valid = 1'b0;
    halt_if   = 1'b0;
    id_ready  = 1'b0;
    pc_mux    = PC_BOOT;
    exc_mux   = EXC_PC_EXCEPTION;
    boot_addr = 31'h0000_0400;  // boot at 0x800
    trap_base = 24'h00_0020;
    irq_cause = 6'd45;          // cause msb set, kept since it is not folded
    dm_halt   = 30'h0000_0a00;
    mepc      = 32'h0000_1400;
    depc      = 32'h0000_1600;
    jmp_id    = 32'h0000_1000;
    jmp_ex    = 32'h0000_1200;
    err_en    = 1'b0;
    err_adr   = '0;
    last_pc   = '0;
    for (int i = 0; i < 4096; i++) i_mem.mem[i] = (32'(i) * FILL_K) | 32'h3;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    reset_and_boot();
    target_select();
    flush_open_cycle();
    back_pressure();
    compressed_words();
    bus_error_clear();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* verification/tb_wb_mem.sv */
/* word-read Wishbone classic memory, 16 KB mirrored over the address space;
   each cycle waits 0 to 3 extra cycles, one address can be set to answer err */
`timescale 1ns/1ps

module tb_wb_mem (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic [31:0] adr_i,
  input  logic        err_en_i,   // enables error injection
  input  logic [31:0] err_adr_i,  // word that answers with err
  output logic        ack_o,
  output logic        err_o,
  output logic [31:0] dat_o
);

  logic [31:0] mem [4096];  // loaded by the testbench
  logic        active;      // cycle seen, delay counting
  logic [1:0]  wait_cnt;

  // registered response, so ack never shows up in the cycle that opens it
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      dat_o    <= '0;
      active   <= 1'b0;
      wait_cnt <= '0;
    end else begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o && !err_o) begin
        if (!active) begin
          active   <= 1'b1;
          wait_cnt <= 2'($urandom % 4);  // per-cycle ack delay
        end else if (wait_cnt == 2'd0) begin
          active <= 1'b0;
          dat_o  <= mem[adr_i[13:2]];
          if (err_en_i && adr_i[31:2] == err_adr_i[31:2]) err_o <= 1'b1;
          else                                              ack_o <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
  end

endmodule
